//--- include/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath and register file sizes
`define ID_DATA_W   32
`define ID_ADDR_W   5
`define ID_NREGS    32

// apb byte address, word index in bits 6:2
`define APB_ADDR_W  7

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// special function codes
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_MOVZ     6'b001010
`define FN_MOVN     6'b001011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif

//--- rtl/id_pkg.sv
`default_nettype none

`include "id_defs.svh"

package id_pkg;

    typedef struct packed {
        logic [5:0]            op;
        logic [`ID_ADDR_W-1:0] rs;
        logic [`ID_ADDR_W-1:0] rt;
        logic [`ID_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [`ID_ADDR_W-1:0] rs;
        logic [`ID_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    // one instruction word, seen as either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_MOVZ  = 8'b00001010,
        ALU_MOVN  = 8'b00001011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alu_sel_e;

    typedef enum logic [1:0] {
        WR_NEVER,
        WR_ALWAYS,
        WR_IF_NONZERO,
        WR_IF_ZERO
    } wr_cond_e;

    // write from a later stage, 38 bits
    typedef struct packed {
        logic                  wen;
        logic [`ID_ADDR_W-1:0] waddr;
        logic [`ID_DATA_W-1:0] wdata;
    } fwd_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`ID_DATA_W-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               aluop;
        alu_sel_e              alusel;
        logic                  rd_en1;
        logic                  rd_en2;
        logic [`ID_ADDR_W-1:0] raddr1;
        logic [`ID_ADDR_W-1:0] raddr2;
        logic [`ID_ADDR_W-1:0] waddr;
        wr_cond_e              wr_cond;
        logic [`ID_DATA_W-1:0] imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               aluop;
        alu_sel_e              alusel;
        logic [`ID_DATA_W-1:0] op1;
        logic [`ID_DATA_W-1:0] op2;
        logic [`ID_ADDR_W-1:0] waddr;
        logic                  wen;
    } id_ex_t;

endpackage

`default_nettype wire

//--- rtl/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module gpr_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  id_pkg::apb_req_t      apb,
    output logic [`ID_DATA_W-1:0] prdata,
    input  logic [`ID_ADDR_W-1:0] raddr1,
    input  logic [`ID_ADDR_W-1:0] raddr2,
    output logic [`ID_DATA_W-1:0] rdata1,
    output logic [`ID_DATA_W-1:0] rdata2
);

    logic [`ID_DATA_W-1:0] regs [`ID_NREGS];

    logic [`ID_ADDR_W-1:0] apb_idx;
    logic                  apb_access;
    logic                  apb_wr;
    logic                  apb_rd;

    // word index from the byte address
    assign apb_idx    = apb.paddr[`APB_ADDR_W-1:2];
    assign apb_access = apb.psel && apb.penable;
    assign apb_wr     = apb_access && apb.pwrite;
    assign apb_rd     = apb_access && !apb.pwrite;

    // register 0 is never written so it stays at its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (apb_wr && apb_idx != '0) begin
            regs[apb_idx] <= apb.pwdata;
        end
    end

    // readback only during the access cycle
    assign prdata = apb_rd ? regs[apb_idx] : '0;

    // decode read ports, old value during a same-cycle apb write
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module inst_decoder (
    input  id_pkg::inst_u     inst,
    output id_pkg::dec_ctrl_t ctrl
);

    import id_pkg::*;

    logic [`ID_DATA_W-1:0] imm_zext;
    logic [`ID_DATA_W-1:0] imm_sext;
    logic [`ID_DATA_W-1:0] imm_upper;
    logic                  imm_form;
    logic                  shamt_form;

    assign imm_zext  = {16'h0, inst.i.imm};
    assign imm_sext  = {{16{inst.i.imm[15]}}, inst.i.imm};
    assign imm_upper = {inst.i.imm, 16'h0};

    assign imm_form = inst.i.op inside {`OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI,
                                        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};

    always_comb begin
        ctrl        = '0;
        ctrl.raddr1 = inst.r.rs;
        ctrl.raddr2 = inst.r.rt;
        shamt_form  = 1'b0;

        case (inst.r.op)
            `OP_SPECIAL: begin
                ctrl.waddr   = inst.r.rd;
                ctrl.rd_en1  = 1'b1;
                ctrl.rd_en2  = 1'b1;
                ctrl.wr_cond = WR_ALWAYS;
                // register forms need a zero shamt field
                ctrl.valid   = (inst.r.shamt == '0);
                case (inst.r.funct)
                    `FN_OR: begin
                        ctrl.aluop  = ALU_OR;
                        ctrl.alusel = SEL_LOGIC;
                    end
                    `FN_AND: begin
                        ctrl.aluop  = ALU_AND;
                        ctrl.alusel = SEL_LOGIC;
                    end
                    `FN_XOR: begin
                        ctrl.aluop  = ALU_XOR;
                        ctrl.alusel = SEL_LOGIC;
                    end
                    `FN_NOR: begin
                        ctrl.aluop  = ALU_NOR;
                        ctrl.alusel = SEL_LOGIC;
                    end
                    `FN_SLLV, `FN_SLL: begin
                        ctrl.aluop  = ALU_SLL;
                        ctrl.alusel = SEL_SHIFT;
                        shamt_form  = (inst.r.funct == `FN_SLL);
                    end
                    `FN_SRLV, `FN_SRL: begin
                        ctrl.aluop  = ALU_SRL;
                        ctrl.alusel = SEL_SHIFT;
                        shamt_form  = (inst.r.funct == `FN_SRL);
                    end
                    `FN_SRAV, `FN_SRA: begin
                        ctrl.aluop  = ALU_SRA;
                        ctrl.alusel = SEL_SHIFT;
                        shamt_form  = (inst.r.funct == `FN_SRA);
                    end
                    `FN_ADD: begin
                        ctrl.aluop  = ALU_ADD;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_ADDU: begin
                        ctrl.aluop  = ALU_ADDU;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_SUB: begin
                        ctrl.aluop  = ALU_SUB;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_SUBU: begin
                        ctrl.aluop  = ALU_SUBU;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_SLT: begin
                        ctrl.aluop  = ALU_SLT;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_SLTU: begin
                        ctrl.aluop  = ALU_SLTU;
                        ctrl.alusel = SEL_ARITH;
                    end
                    `FN_MOVN: begin
                        ctrl.aluop   = ALU_MOVN;
                        ctrl.alusel  = SEL_MOVE;
                        ctrl.wr_cond = WR_IF_NONZERO;
                    end
                    `FN_MOVZ: begin
                        ctrl.aluop   = ALU_MOVZ;
                        ctrl.alusel  = SEL_MOVE;
                        ctrl.wr_cond = WR_IF_ZERO;
                    end
                    default: begin
                        ctrl.valid = 1'b0;
                    end
                endcase
            end
            `OP_ORI: begin
                ctrl.aluop  = ALU_OR;
                ctrl.alusel = SEL_LOGIC;
                ctrl.imm    = imm_zext;
            end
            `OP_ANDI: begin
                ctrl.aluop  = ALU_AND;
                ctrl.alusel = SEL_LOGIC;
                ctrl.imm    = imm_zext;
            end
            `OP_XORI: begin
                ctrl.aluop  = ALU_XOR;
                ctrl.alusel = SEL_LOGIC;
                ctrl.imm    = imm_zext;
            end
            // lui is an or with rs, which is normally r0
            `OP_LUI: begin
                ctrl.aluop  = ALU_OR;
                ctrl.alusel = SEL_LOGIC;
                ctrl.imm    = imm_upper;
            end
            `OP_ADDI: begin
                ctrl.aluop  = ALU_ADDI;
                ctrl.alusel = SEL_ARITH;
                ctrl.imm    = imm_sext;
            end
            `OP_ADDIU: begin
                ctrl.aluop  = ALU_ADDIU;
                ctrl.alusel = SEL_ARITH;
                ctrl.imm    = imm_sext;
            end
            `OP_SLTI: begin
                ctrl.aluop  = ALU_SLT;
                ctrl.alusel = SEL_ARITH;
                ctrl.imm    = imm_sext;
            end
            `OP_SLTIU: begin
                ctrl.aluop  = ALU_SLTU;
                ctrl.alusel = SEL_ARITH;
                ctrl.imm    = imm_sext;
            end
            default: begin
                ctrl.valid = 1'b0;
            end
        endcase

        // immediate forms: rs in, rt out
        if (imm_form) begin
            ctrl.valid   = 1'b1;
            ctrl.rd_en1  = 1'b1;
            ctrl.waddr   = inst.i.rt;
            ctrl.wr_cond = WR_ALWAYS;
        end

        // sll/srl/sra take shamt as op1 and need rs zero
        if (shamt_form) begin
            ctrl.rd_en1 = 1'b0;
            ctrl.imm    = {{(`ID_DATA_W-5){1'b0}}, inst.r.shamt};
            ctrl.valid  = (inst.r.rs == '0);
        end
    end

endmodule

`default_nettype wire

//--- rtl/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module operand_forward (
    input  id_pkg::dec_ctrl_t     ctrl,
    input  logic [`ID_DATA_W-1:0] rdata1,
    input  logic [`ID_DATA_W-1:0] rdata2,
    input  id_pkg::fwd_t          ex_fwd,
    input  id_pkg::fwd_t          mem_fwd,
    output id_pkg::id_ex_t        issue_d
);

    import id_pkg::*;

    logic [`ID_DATA_W-1:0] op1;
    logic [`ID_DATA_W-1:0] op2;
    logic                  wen;

    // ex is newer than mem, r0 never forwards
    function automatic logic [`ID_DATA_W-1:0] pick_operand(
        input logic                  rd_en,
        input logic [`ID_ADDR_W-1:0] raddr,
        input logic [`ID_DATA_W-1:0] rdata,
        input fwd_t                  ex,
        input fwd_t                  mem,
        input logic [`ID_DATA_W-1:0] imm
    );
        if (!rd_en) begin
            return imm;
        end else if (raddr == '0) begin
            return '0;
        end else if (ex.wen && ex.waddr == raddr) begin
            return ex.wdata;
        end else if (mem.wen && mem.waddr == raddr) begin
            return mem.wdata;
        end
        return rdata;
    endfunction

    assign op1 = pick_operand(ctrl.rd_en1, ctrl.raddr1, rdata1, ex_fwd, mem_fwd, ctrl.imm);
    assign op2 = pick_operand(ctrl.rd_en2, ctrl.raddr2, rdata2, ex_fwd, mem_fwd, ctrl.imm);

    // conditional moves look at the forwarded op2
    always_comb begin
        case (ctrl.wr_cond)
            WR_ALWAYS:     wen = 1'b1;
            WR_IF_NONZERO: wen = (op2 != '0);
            WR_IF_ZERO:    wen = (op2 == '0);
            default:       wen = 1'b0;
        endcase
    end

    always_comb begin
        issue_d = '0;
        if (ctrl.valid) begin
            issue_d.valid  = 1'b1;
            issue_d.aluop  = ctrl.aluop;
            issue_d.alusel = ctrl.alusel;
            issue_d.op1    = op1;
            issue_d.op2    = op2;
            issue_d.waddr  = ctrl.waddr;
            issue_d.wen    = wen;
        end
    end

endmodule

`default_nettype wire

//--- rtl/id_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  id_pkg::inst_u         inst,
    input  logic                  stall,
    input  id_pkg::fwd_t          ex_fwd,
    input  id_pkg::fwd_t          mem_fwd,
    input  id_pkg::apb_req_t      apb,
    output logic [`ID_DATA_W-1:0] prdata,
    output id_pkg::id_ex_t        issue
);

    import id_pkg::*;

    dec_ctrl_t             ctrl;
    logic [`ID_DATA_W-1:0] rdata1;
    logic [`ID_DATA_W-1:0] rdata2;
    id_ex_t                issue_d;

    gpr_file u_gpr_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .apb    (apb),
        .prdata (prdata),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    operand_forward u_operand_forward (
        .ctrl    (ctrl),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .issue_d (issue_d)
    );

    // id/ex register, a stalled instruction is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue <= '0;
        end else if (!stall) begin
            issue <= issue_d;
        end
    end

endmodule

`default_nettype wire

//--- dv/id_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             stall,
    input id_pkg::apb_req_t apb,
    input id_pkg::id_ex_t   issue
);

    // a reset edge leaves a bubble behind
    reset_clears: assert property (@(posedge clk) !rst_n |=> !issue.valid && !issue.wen)
        else $error("issue valid or wen set after a reset cycle");

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(issue))
        else $error("issue changed across a stalled edge");

    wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        issue.wen |-> issue.valid)
        else $error("issue wen set without valid");

    // access phase only after a setup phase
    access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        apb.penable |-> apb.psel && $past(apb.psel))
        else $error("apb penable without a preceding setup cycle");

endmodule

bind id_stage_top id_stage_checker u_id_stage_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .stall (stall),
    .apb   (apb),
    .issue (issue)
);

`default_nettype wire

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage_tb;

    import id_pkg::*;

    typedef logic [`ID_DATA_W-1:0] regs_t [`ID_NREGS];

    logic                  clk = 1'b0;
    logic                  rst_n;
    inst_u                 inst;
    logic                  stall;
    fwd_t                  ex_fwd;
    fwd_t                  mem_fwd;
    apb_req_t              apb;
    logic [`ID_DATA_W-1:0] prdata;
    id_ex_t                issue;

    regs_t  model;
    id_ex_t last_exp;
    id_ex_t exp_q[$];
    int     due_q[$];
    string  name_q[$];
    int     cycle = 0;
    int     errors = 0;
    integer seed;

    id_stage_top u_id_stage_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .stall   (stall),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .apb     (apb),
        .prdata  (prdata),
        .issue   (issue)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sa);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fwd_t fwd_of(input logic wen, input logic [4:0] addr,
                                    input logic [31:0] data);
        return {wen, addr, data};
    endfunction

    // every address bit shows up in the word
    function automatic logic [31:0] fill_value(input logic [4:0] idx);
        return {3'b101, idx, 3'b011, idx, 3'b110, idx, 3'b001, idx};
    endfunction

    function automatic logic [5:0] funct_at(input logic [4:0] idx);
        case (idx)
            5'd0:    return `FN_SLL;
            5'd1:    return `FN_SRL;
            5'd2:    return `FN_SRA;
            5'd3:    return `FN_SLLV;
            5'd4:    return `FN_SRLV;
            5'd5:    return `FN_SRAV;
            5'd6:    return `FN_OR;
            5'd7:    return `FN_AND;
            5'd8:    return `FN_XOR;
            5'd9:    return `FN_NOR;
            5'd10:   return `FN_ADD;
            5'd11:   return `FN_ADDU;
            5'd12:   return `FN_SUB;
            5'd13:   return `FN_SUBU;
            5'd14:   return `FN_SLT;
            5'd15:   return `FN_SLTU;
            5'd16:   return `FN_MOVN;
            default: return `FN_MOVZ;
        endcase
    endfunction

    function automatic logic [5:0] op_at(input logic [2:0] idx);
        case (idx)
            3'd0:    return `OP_ORI;
            3'd1:    return `OP_ANDI;
            3'd2:    return `OP_XORI;
            3'd3:    return `OP_LUI;
            3'd4:    return `OP_ADDI;
            3'd5:    return `OP_ADDIU;
            3'd6:    return `OP_SLTI;
            default: return `OP_SLTIU;
        endcase
    endfunction

    // newest write wins, r0 is hardwired
    function automatic logic [31:0] operand_value(input regs_t m, input logic [4:0] a,
                                                  input fwd_t ex, input fwd_t mem);
        logic [31:0] v;
        v = m[a];
        if (mem.wen && mem.waddr == a)
            v = mem.wdata;
        if (ex.wen && ex.waddr == a)
            v = ex.wdata;
        if (a == 5'd0)
            v = '0;
        return v;
    endfunction

    function automatic id_ex_t ref_issue(input regs_t m, input logic [31:0] w,
                                         input fwd_t ex, input fwd_t mem);
        id_ex_t      e;
        alu_op_e     aop;
        alu_sel_e    asel;
        wr_cond_e    cond;
        logic        ok;
        logic        use_rs;
        logic        use_rt;
        logic [4:0]  dest;
        logic [15:0] im;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        im = w[15:0];
        ok = 1'b1;
        use_rs = 1'b1;
        use_rt = 1'b0;
        aop = ALU_NOP;
        asel = SEL_NOP;
        cond = WR_ALWAYS;
        imm = '0;
        if (w[31:26] == `OP_SPECIAL) begin
            dest = w[15:11];
            use_rt = 1'b1;
            ok = (w[10:6] == 5'd0);
            case (w[5:0])
                `FN_OR:              aop = ALU_OR;
                `FN_AND:             aop = ALU_AND;
                `FN_XOR:             aop = ALU_XOR;
                `FN_NOR:             aop = ALU_NOR;
                `FN_SLL, `FN_SLLV:   aop = ALU_SLL;
                `FN_SRL, `FN_SRLV:   aop = ALU_SRL;
                `FN_SRA, `FN_SRAV:   aop = ALU_SRA;
                `FN_ADD:             aop = ALU_ADD;
                `FN_ADDU:            aop = ALU_ADDU;
                `FN_SUB:             aop = ALU_SUB;
                `FN_SUBU:            aop = ALU_SUBU;
                `FN_SLT:             aop = ALU_SLT;
                `FN_SLTU:            aop = ALU_SLTU;
                `FN_MOVN:            aop = ALU_MOVN;
                `FN_MOVZ:            aop = ALU_MOVZ;
                default:             ok = 1'b0;
            endcase
            case (w[5:0])
                `FN_OR, `FN_AND, `FN_XOR, `FN_NOR: asel = SEL_LOGIC;
                `FN_MOVN, `FN_MOVZ:               asel = SEL_MOVE;
                `FN_SLL, `FN_SRL, `FN_SRA,
                `FN_SLLV, `FN_SRLV, `FN_SRAV:     asel = SEL_SHIFT;
                default:                          asel = SEL_ARITH;
            endcase
            if (w[5:0] == `FN_MOVN)
                cond = WR_IF_NONZERO;
            if (w[5:0] == `FN_MOVZ)
                cond = WR_IF_ZERO;
            // shift by shamt: op1 is the amount, rs must be zero
            if (w[5:0] == `FN_SLL || w[5:0] == `FN_SRL || w[5:0] == `FN_SRA) begin
                use_rs = 1'b0;
                imm = {27'd0, w[10:6]};
                ok = (w[25:21] == 5'd0);
            end
        end else begin
            dest = w[20:16];
            case (w[31:26])
                `OP_ORI, `OP_LUI: aop = ALU_OR;
                `OP_ANDI:         aop = ALU_AND;
                `OP_XORI:         aop = ALU_XOR;
                `OP_ADDI:         aop = ALU_ADDI;
                `OP_ADDIU:        aop = ALU_ADDIU;
                `OP_SLTI:         aop = ALU_SLT;
                `OP_SLTIU:        aop = ALU_SLTU;
                default:          ok = 1'b0;
            endcase
            // opcodes 0x0c..0x0f are the logic group
            asel = w[28] ? SEL_LOGIC : SEL_ARITH;
            if (w[31:26] == `OP_LUI)
                imm = {im, 16'h0};
            else if (w[28])
                imm = {16'h0, im};
            else
                imm = {{16{im[15]}}, im};
        end
        a = use_rs ? operand_value(m, w[25:21], ex, mem) : imm;
        b = use_rt ? operand_value(m, w[20:16], ex, mem) : imm;
        e = '0;
        if (ok) begin
            e.valid = 1'b1;
            e.aluop = aop;
            e.alusel = asel;
            e.op1 = a;
            e.op2 = b;
            e.waddr = dest;
            case (cond)
                WR_IF_NONZERO: e.wen = (b != '0);
                WR_IF_ZERO:    e.wen = (b == '0);
                default:       e.wen = 1'b1;
            endcase
        end
        return e;
    endfunction

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_issue(input string name, input id_ex_t exp, input id_ex_t act);
        if (act !== exp) begin
            $display("** Error [%s] issue expected %h (%s) actual %h (%s)",
                     name, exp, exp.aluop.name(), act, act.aluop.name());
            abort_run("issue does not match the expected bundle");
        end
    endtask

    task automatic check_word(input string name, input logic [`ID_DATA_W-1:0] exp,
                              input logic [`ID_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] word expected %h actual %h", name, exp, act);
            abort_run("prdata does not match the model");
        end
    endtask

    // issue is settled by the falling edge after the sampling edge
    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] < cycle)
            abort_run("an issue check was skipped");
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            check_issue(name_q.pop_front(), exp_q.pop_front(), issue);
            due_q.pop_front();
        end
    end

    task automatic drive_inst(input string name, input logic [31:0] w, input fwd_t ex,
                              input fwd_t mem, input logic stl);
        id_ex_t exp;
        @(posedge clk);
        #1;
        inst = w;
        ex_fwd = ex;
        mem_fwd = mem;
        stall = stl;
        if (stl)
            exp = last_exp;
        else
            exp = ref_issue(model, w, ex, mem);
        last_exp = exp;
        exp_q.push_back(exp);
        due_q.push_back(cycle + 1);
        name_q.push_back(name);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            abort_run("timeout while waiting for issue checks to complete");
    endtask

    task automatic apb_write(input logic [4:0] idx, input logic [31:0] data);
        @(posedge clk);
        #1;
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = 1'b1;
        apb.paddr = {idx, 2'b00};
        apb.pwdata = data;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        @(posedge clk);
        #1;
        apb = '0;
        if (idx != 5'd0)
            model[idx] = data;
    endtask

    task automatic apb_read(input logic [4:0] idx);
        @(posedge clk);
        #1;
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = 1'b0;
        apb.paddr = {idx, 2'b00};
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        @(negedge clk);
        check_word($sformatf("apb_read_r%0d", idx), model[idx], prdata);
        @(posedge clk);
        #1;
        apb = '0;
    endtask

    // small register numbers so forwards hit often
    task automatic random_case(input int n);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] w;
        logic [4:0]  k;
        fwd_t        ex;
        fwd_t        mem;
        r = $random(seed);
        d = $random(seed);
        k = r[4:0];
        if (k < 5'd3)
            w = rtype_word(funct_at(k), 5'd0, {2'b00, r[10:8]}, r[15:11], d[4:0]);
        else if (k < 5'd18)
            w = rtype_word(funct_at(k), {2'b00, r[7:5]}, {2'b00, r[10:8]}, r[15:11], 5'd0);
        else if (k < 5'd26)
            w = itype_word(op_at(k[2:0]), {2'b00, r[7:5]}, {2'b00, r[10:8]}, d[15:0]);
        else
            w = d;
        ex = fwd_of(r[16], {2'b00, r[19:17]}, r[24] ? 32'h0 : d);
        mem = fwd_of(r[20], {2'b00, r[23:21]}, $random(seed));
        drive_inst($sformatf("rand_%0d", n), w, ex, mem, (n > 0) && (r[27:25] == 3'd0));
    endtask

    initial begin
        seed = 32'hda729e8c;
        rst_n = 1'b0;
        inst = '0;
        stall = 1'b0;
        ex_fwd = '0;
        mem_fwd = '0;
        apb = '0;
        last_exp = '0;
        for (int i = 0; i < `ID_NREGS; i++)
            model[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_issue("reset", '0, issue);

        // load and read back the register file
        for (int i = 1; i < `ID_NREGS; i++)
            apb_write(5'(i), fill_value(5'(i)));
        apb_write(5'd0, 32'hffff_ffff);
        for (int i = 0; i < `ID_NREGS; i++)
            apb_read(5'(i));

        drive_inst("r_or", rtype_word(`FN_OR, 5'd3, 5'd7, 5'd12, 5'd0), '0, '0, 1'b0);
        drive_inst("r_and", rtype_word(`FN_AND, 5'd3, 5'd7, 5'd12, 5'd0), '0, '0, 1'b0);
        drive_inst("r_xor", rtype_word(`FN_XOR, 5'd8, 5'd2, 5'd31, 5'd0), '0, '0, 1'b0);
        drive_inst("r_nor", rtype_word(`FN_NOR, 5'd8, 5'd2, 5'd1, 5'd0), '0, '0, 1'b0);
        drive_inst("r_add", rtype_word(`FN_ADD, 5'd9, 5'd17, 5'd5, 5'd0), '0, '0, 1'b0);
        drive_inst("r_addu", rtype_word(`FN_ADDU, 5'd9, 5'd17, 5'd5, 5'd0), '0, '0, 1'b0);
        drive_inst("r_sub", rtype_word(`FN_SUB, 5'd30, 5'd1, 5'd6, 5'd0), '0, '0, 1'b0);
        drive_inst("r_subu", rtype_word(`FN_SUBU, 5'd30, 5'd1, 5'd6, 5'd0), '0, '0, 1'b0);
        drive_inst("r_slt", rtype_word(`FN_SLT, 5'd4, 5'd11, 5'd20, 5'd0), '0, '0, 1'b0);
        drive_inst("r_sltu", rtype_word(`FN_SLTU, 5'd4, 5'd11, 5'd20, 5'd0), '0, '0, 1'b0);
        drive_inst("r_sllv", rtype_word(`FN_SLLV, 5'd13, 5'd14, 5'd15, 5'd0), '0, '0, 1'b0);
        drive_inst("r_srlv", rtype_word(`FN_SRLV, 5'd13, 5'd14, 5'd15, 5'd0), '0, '0, 1'b0);
        drive_inst("r_srav", rtype_word(`FN_SRAV, 5'd13, 5'd14, 5'd15, 5'd0), '0, '0, 1'b0);
        wait_drain();

        // immediates with the sign bit set tell zero and sign extension apart
        drive_inst("i_ori", itype_word(`OP_ORI, 5'd3, 5'd9, 16'h8f01), '0, '0, 1'b0);
        drive_inst("i_andi", itype_word(`OP_ANDI, 5'd3, 5'd9, 16'h8f01), '0, '0, 1'b0);
        drive_inst("i_xori", itype_word(`OP_XORI, 5'd21, 5'd2, 16'hc0de), '0, '0, 1'b0);
        drive_inst("i_lui", itype_word(`OP_LUI, 5'd0, 5'd2, 16'hbeef), '0, '0, 1'b0);
        drive_inst("i_addi", itype_word(`OP_ADDI, 5'd6, 5'd7, 16'hfff3), '0, '0, 1'b0);
        drive_inst("i_addiu", itype_word(`OP_ADDIU, 5'd6, 5'd7, 16'h0042), '0, '0, 1'b0);
        drive_inst("i_slti", itype_word(`OP_SLTI, 5'd10, 5'd0, 16'h8000), '0, '0, 1'b0);
        drive_inst("i_sltiu", itype_word(`OP_SLTIU, 5'd10, 5'd25, 16'h7fff), '0, '0, 1'b0);
        drive_inst("s_sll", rtype_word(`FN_SLL, 5'd0, 5'd9, 5'd3, 5'd13), '0, '0, 1'b0);
        drive_inst("s_srl", rtype_word(`FN_SRL, 5'd0, 5'd9, 5'd3, 5'd31), '0, '0, 1'b0);
        drive_inst("s_sra", rtype_word(`FN_SRA, 5'd0, 5'd9, 5'd3, 5'd1), '0, '0, 1'b0);
        wait_drain();

        drive_inst("f_none", rtype_word(`FN_ADDU, 5'd5, 5'd6, 5'd10, 5'd0), '0, '0, 1'b0);
        drive_inst("f_mem_rs", rtype_word(`FN_ADDU, 5'd5, 5'd6, 5'd10, 5'd0), '0,
                   fwd_of(1'b1, 5'd5, 32'h1111_2222), 1'b0);
        drive_inst("f_ex_over_mem", rtype_word(`FN_ADDU, 5'd5, 5'd6, 5'd10, 5'd0),
                   fwd_of(1'b1, 5'd5, 32'h3333_4444), fwd_of(1'b1, 5'd5, 32'h5555_6666), 1'b0);
        drive_inst("f_mem_rt", rtype_word(`FN_OR, 5'd5, 5'd6, 5'd10, 5'd0),
                   fwd_of(1'b0, 5'd6, 32'h7777_8888), fwd_of(1'b1, 5'd6, 32'h9999_aaaa), 1'b0);
        drive_inst("f_r0", rtype_word(`FN_OR, 5'd0, 5'd0, 5'd10, 5'd0),
                   fwd_of(1'b1, 5'd0, 32'hdead_0001), fwd_of(1'b1, 5'd0, 32'hdead_0002), 1'b0);
        drive_inst("f_miss", itype_word(`OP_ADDI, 5'd5, 5'd6, 16'h0010),
                   fwd_of(1'b1, 5'd7, 32'hbbbb_cccc), '0, 1'b0);
        wait_drain();

        drive_inst("m_movn_reg", rtype_word(`FN_MOVN, 5'd3, 5'd4, 5'd8, 5'd0), '0, '0, 1'b0);
        drive_inst("m_movz_reg", rtype_word(`FN_MOVZ, 5'd3, 5'd4, 5'd8, 5'd0), '0, '0, 1'b0);
        drive_inst("m_movn_fwd0", rtype_word(`FN_MOVN, 5'd3, 5'd4, 5'd8, 5'd0),
                   fwd_of(1'b1, 5'd4, 32'h0), '0, 1'b0);
        drive_inst("m_movz_fwd0", rtype_word(`FN_MOVZ, 5'd3, 5'd4, 5'd8, 5'd0),
                   '0, fwd_of(1'b1, 5'd4, 32'h0), 1'b0);
        drive_inst("m_movz_r0", rtype_word(`FN_MOVZ, 5'd3, 5'd0, 5'd8, 5'd0), '0, '0, 1'b0);
        wait_drain();

        drive_inst("u_jump", itype_word(6'b000010, 5'd1, 5'd2, 16'h1234), '0, '0, 1'b0);
        drive_inst("u_mult", rtype_word(6'b011000, 5'd1, 5'd2, 5'd0, 5'd0), '0, '0, 1'b0);
        drive_inst("u_add_shamt", rtype_word(`FN_ADD, 5'd1, 5'd2, 5'd3, 5'd3), '0, '0, 1'b0);
        drive_inst("u_sll_rs", rtype_word(`FN_SLL, 5'd2, 5'd2, 5'd3, 5'd4), '0, '0, 1'b0);
        wait_drain();

        drive_inst("st_before", rtype_word(`FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0), '0, '0, 1'b0);
        drive_inst("st_hold1", rtype_word(`FN_XOR, 5'd4, 5'd5, 5'd6, 5'd0), '0, '0, 1'b1);
        drive_inst("st_hold2", rtype_word(`FN_OR, 5'd7, 5'd8, 5'd9, 5'd0), '0, '0, 1'b1);
        drive_inst("st_hold3", itype_word(`OP_ANDI, 5'd1, 5'd2, 16'hffff), '0, '0, 1'b1);
        drive_inst("st_after", rtype_word(`FN_SUB, 5'd11, 5'd12, 5'd13, 5'd0), '0, '0, 1'b0);
        wait_drain();

        for (int n = 0; n < 300; n++)
            random_case(n);
        wait_drain();

        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
rtl/id_pkg.sv
rtl/gpr_file.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/id_stage_top.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = id_stage_tb
FILELIST = sources.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
